// ==== rv_pkg.sv ====
// RV32I single-cycle core shared definitions
// Major opcodes, ALU function codes, data path select encodings, reset PC
package rv_pkg;

  localparam int XLEN = 32;

  localparam logic [XLEN-1:0] INITIAL_PC = 32'h0000_0000;

  // --------------------------------------------------------------------------
  // Major opcodes, inst[6:0]
  // --------------------------------------------------------------------------
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
  localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
  localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
  localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;

  // --------------------------------------------------------------------------
  // ALU functions
  // --------------------------------------------------------------------------
  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_SLL  = 5'd2,
    ALU_SLT  = 5'd3,
    ALU_SLTU = 5'd4,
    ALU_XOR  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_OR   = 5'd8,
    ALU_AND  = 5'd9,
    // Branch compares, result is 0 or 1
    ALU_SEQ  = 5'd10,
    ALU_SNE  = 5'd11,
    ALU_SGE  = 5'd12,
    ALU_SGEU = 5'd13
  } alu_function_t;

  // --------------------------------------------------------------------------
  // Data path selects
  // --------------------------------------------------------------------------
  typedef enum logic [1:0] {
    NEXT_PC_PLUS_4   = 2'd0,
    NEXT_PC_PLUS_IMM = 2'd1,
    NEXT_PC_ALU      = 2'd2,
    NEXT_PC_ZERO     = 2'd3
  } next_pc_select_t;

  typedef enum logic [2:0] {
    WB_ALU       = 3'd0,
    WB_MEM       = 3'd1,
    WB_PC_PLUS_4 = 3'd2,
    WB_IMM       = 3'd3
  } reg_writeback_select_t;

  typedef enum logic {OPA_RS1 = 1'b0, OPA_PC = 1'b1} alu_operand_a_select_t;

  typedef enum logic {OPB_RS2 = 1'b0, OPB_IMM = 1'b1} alu_operand_b_select_t;

endpackage

// ==== alu.sv ====
// 32-bit integer ALU
// Arithmetic, logic, shifts and compares, plus a zero flag for branches
`timescale 1ns/1ps

module alu import rv_pkg::*; (
  input  alu_function_t   alu_function,
  input  logic [XLEN-1:0] operand_a,
  input  logic [XLEN-1:0] operand_b,
  output logic [XLEN-1:0] result,
  output logic            result_equal_zero
);

  logic [4:0] shamt;

  // Only the low five bits count for shifts
  assign shamt = operand_b[4:0];

  always_comb begin
    case (alu_function)
      ALU_ADD:  result = operand_a + operand_b;
      ALU_SUB:  result = operand_a - operand_b;
      ALU_SLL:  result = operand_a << shamt;
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, operand_a < operand_b};
      ALU_XOR:  result = operand_a ^ operand_b;
      ALU_SRL:  result = operand_a >> shamt;
      ALU_SRA:  result = $unsigned($signed(operand_a) >>> shamt);
      ALU_OR:   result = operand_a | operand_b;
      ALU_AND:  result = operand_a & operand_b;
      ALU_SEQ:  result = {{(XLEN-1){1'b0}}, operand_a == operand_b};
      ALU_SNE:  result = {{(XLEN-1){1'b0}}, operand_a != operand_b};
      ALU_SGE:  result = {{(XLEN-1){1'b0}}, $signed(operand_a) >= $signed(operand_b)};
      ALU_SGEU: result = {{(XLEN-1){1'b0}}, operand_a >= operand_b};
      default:  result = '0;
    endcase
  end

  assign result_equal_zero = (result == '0);

  // Control must only ever issue a defined function code
  always_comb begin
    assert #0 (alu_function inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
                                    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
                                    ALU_SEQ, ALU_SNE, ALU_SGE, ALU_SGEU})
      else $error("alu: undefined function code %0d", alu_function);
  end

endmodule

// ==== regfile.sv ====
// Integer register file, 32 x 32
// Two combinational read ports, one write port, x0 reads as zero
`timescale 1ns/1ps

module regfile import rv_pkg::*; (
  input  logic            clock,
  input  logic            write_enable,
  input  logic [4:0]      rd_address,
  input  logic [XLEN-1:0] rd_data,
  input  logic [4:0]      rs1_address,
  output logic [XLEN-1:0] rs1_data,
  input  logic [4:0]      rs2_address,
  output logic [XLEN-1:0] rs2_data
);

  logic [XLEN-1:0] regs [32];

  // Entry 0 is never written
  always_ff @(posedge clock) begin
    if (write_enable && (rd_address != 5'd0)) begin
      regs[rd_address] <= rd_data;
    end
  end

  assign rs1_data = (rs1_address == 5'd0) ? '0 : regs[rs1_address];
  assign rs2_data = (rs2_address == 5'd0) ? '0 : regs[rs2_address];

  // Written value reads back in the next cycle
  // A write aimed at x0 still reads zero
  write_read_back: assert property (
    @(posedge clock) write_enable |=>
      (rs1_address != $past(rd_address)) ||
      (rs1_data == (($past(rd_address) == 5'd0) ? '0 : $past(rd_data))))
    else $error("regfile: read after write returned the wrong value");

endmodule

// ==== instruction_decoder.sv ====
// RV32I instruction decoder
// Splits out the instruction fields and builds the sign-extended immediate
`timescale 1ns/1ps

module instruction_decoder import rv_pkg::*; (
  input  logic [31:0]     inst,
  output logic [6:0]      inst_opcode,
  output logic [2:0]      inst_funct3,
  output logic [6:0]      inst_funct7,
  output logic [4:0]      inst_rd,
  output logic [4:0]      inst_rs1,
  output logic [4:0]      inst_rs2,
  output logic [XLEN-1:0] immediate
);

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  // Fixed field positions
  assign inst_opcode = inst[6:0];
  assign inst_rd     = inst[11:7];
  assign inst_funct3 = inst[14:12];
  assign inst_rs1    = inst[19:15];
  assign inst_rs2    = inst[24:20];
  assign inst_funct7 = inst[31:25];

  // --------------------------------------------------------------------------
  // Immediate formats, sign bit is always inst[31]
  // --------------------------------------------------------------------------
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (inst_opcode)
      OPCODE_JALR,
      OPCODE_LOAD,
      OPCODE_OP_IMM: immediate = imm_i;
      OPCODE_STORE:  immediate = imm_s;
      OPCODE_BRANCH: immediate = imm_b;
      OPCODE_LUI,
      OPCODE_AUIPC:  immediate = imm_u;
      OPCODE_JAL:    immediate = imm_j;
      // R-type and unknown
      default:       immediate = '0;
    endcase
  end

endmodule

// ==== singlecycle_control.sv ====
// Single-cycle control unit
// Opcode table driving every data path select and write enable
`timescale 1ns/1ps

module singlecycle_control import rv_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [6:0]            inst_opcode,
  input  logic [2:0]            inst_funct3,
  input  logic [6:0]            inst_funct7,
  input  logic                  alu_result_equal_zero,
  output logic                  pc_write_enable,
  output logic                  regfile_write_enable,
  output logic                  data_mem_write,
  output alu_function_t         alu_function,
  output alu_operand_a_select_t alu_operand_a_select,
  output alu_operand_b_select_t alu_operand_b_select,
  output next_pc_select_t       next_pc_select,
  output reg_writeback_select_t reg_writeback_select
);

  logic            rd_write;
  logic            mem_write;
  logic            is_branch;
  next_pc_select_t base_next_pc;

  // funct3 to ALU function for OP and OP_IMM; alt is funct7 bit 5
  function automatic alu_function_t decode_arith(input logic [2:0] funct3,
                                                 input logic       alt,
                                                 input logic       reg_op);
    alu_function_t f;
    case (funct3)
      3'b000:  f = (alt && reg_op) ? ALU_SUB : ALU_ADD;
      3'b001:  f = ALU_SLL;
      3'b010:  f = ALU_SLT;
      3'b011:  f = ALU_SLTU;
      3'b100:  f = ALU_XOR;
      3'b101:  f = alt ? ALU_SRA : ALU_SRL;
      3'b110:  f = ALU_OR;
      default: f = ALU_AND;
    endcase
    return f;
  endfunction

  // --------------------------------------------------------------------------
  // Opcode table
  // --------------------------------------------------------------------------
  always_comb begin
    rd_write             = 1'b0;
    mem_write            = 1'b0;
    is_branch            = 1'b0;
    alu_function         = ALU_ADD;
    alu_operand_a_select = OPA_RS1;
    alu_operand_b_select = OPB_IMM;
    base_next_pc         = NEXT_PC_PLUS_4;
    reg_writeback_select = WB_ALU;
    case (inst_opcode)
      OPCODE_LUI: begin
        rd_write             = 1'b1;
        reg_writeback_select = WB_IMM;
      end
      OPCODE_AUIPC: begin
        rd_write             = 1'b1;
        alu_operand_a_select = OPA_PC;
      end
      OPCODE_JAL: begin
        rd_write             = 1'b1;
        base_next_pc         = NEXT_PC_PLUS_IMM;
        reg_writeback_select = WB_PC_PLUS_4;
      end
      OPCODE_JALR: begin
        rd_write             = 1'b1;
        base_next_pc         = NEXT_PC_ALU;
        reg_writeback_select = WB_PC_PLUS_4;
      end
      OPCODE_BRANCH: begin
        // Compare result is zero exactly when the branch is taken
        alu_operand_b_select = OPB_RS2;
        is_branch            = 1'b1;
        case (inst_funct3)
          3'b000:  alu_function = ALU_SNE;
          3'b001:  alu_function = ALU_SEQ;
          3'b100:  alu_function = ALU_SGE;
          3'b101:  alu_function = ALU_SLT;
          3'b110:  alu_function = ALU_SGEU;
          3'b111:  alu_function = ALU_SLTU;
          default: is_branch    = 1'b0;
        endcase
      end
      OPCODE_LOAD: begin
        // Word loads only
        rd_write             = (inst_funct3 == 3'b010);
        reg_writeback_select = WB_MEM;
      end
      OPCODE_STORE: begin
        mem_write = (inst_funct3 == 3'b010);
      end
      OPCODE_OP_IMM: begin
        rd_write     = 1'b1;
        alu_function = decode_arith(inst_funct3, inst_funct7[5], 1'b0);
      end
      OPCODE_OP: begin
        rd_write             = 1'b1;
        alu_operand_b_select = OPB_RS2;
        alu_function         = decode_arith(inst_funct3, inst_funct7[5], 1'b1);
      end
      default: ;
    endcase
  end

  // Branch decision kept apart from the table since it depends on the ALU
  always_comb begin
    if (is_branch && alu_result_equal_zero) begin
      next_pc_select = NEXT_PC_PLUS_IMM;
    end else begin
      next_pc_select = base_next_pc;
    end
  end

  assign pc_write_enable      = !reset;
  assign regfile_write_enable = rd_write && !reset;
  assign data_mem_write       = mem_write && !reset;

  no_store_with_writeback: assert property (
    @(posedge clock) !(data_mem_write && regfile_write_enable))
    else $error("control: store and register write in the same cycle");

endmodule

// ==== singlecycle_datapath.sv ====
// Single-cycle data path
// PC register, operand and writeback selection, next-PC logic,
// ALU, register file and decoder
`timescale 1ns/1ps

module singlecycle_datapath import rv_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  pc_write_enable,
  input  logic                  regfile_write_enable,
  input  alu_function_t         alu_function,
  input  alu_operand_a_select_t alu_operand_a_select,
  input  alu_operand_b_select_t alu_operand_b_select,
  input  next_pc_select_t       next_pc_select,
  input  reg_writeback_select_t reg_writeback_select,
  input  logic [31:0]           inst,
  input  logic [XLEN-1:0]       data_mem_read_data,
  output logic [XLEN-1:0]       data_mem_address,
  output logic [XLEN-1:0]       data_mem_write_data,
  output logic                  alu_result_equal_zero,
  output logic [2:0]            inst_funct3,
  output logic [6:0]            inst_funct7,
  output logic [6:0]            inst_opcode,
  output logic [XLEN-1:0]       pc
);

  logic [4:0]      inst_rd;
  logic [4:0]      inst_rs1;
  logic [4:0]      inst_rs2;
  logic [XLEN-1:0] immediate;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] operand_a;
  logic [XLEN-1:0] operand_b;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] pc_plus_4;
  logic [XLEN-1:0] pc_plus_immediate;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] writeback_data;

  // --------------------------------------------------------------------------
  // Program counter
  // --------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= INITIAL_PC;
    end else if (pc_write_enable) begin
      pc <= next_pc;
    end
  end

  assign pc_plus_4         = pc + 32'd4;
  assign pc_plus_immediate = pc + immediate;

  always_comb begin
    case (next_pc_select)
      NEXT_PC_PLUS_4:   next_pc = pc_plus_4;
      NEXT_PC_PLUS_IMM: next_pc = pc_plus_immediate;
      // JALR target, bit 0 dropped
      NEXT_PC_ALU:      next_pc = {alu_result[XLEN-1:1], 1'b0};
      NEXT_PC_ZERO:     next_pc = '0;
      default:          next_pc = pc_plus_4;
    endcase
  end

  // --------------------------------------------------------------------------
  // Decode, register file, ALU
  // --------------------------------------------------------------------------
  instruction_decoder idec (
    .inst        (inst),
    .inst_opcode (inst_opcode),
    .inst_funct3 (inst_funct3),
    .inst_funct7 (inst_funct7),
    .inst_rd     (inst_rd),
    .inst_rs1    (inst_rs1),
    .inst_rs2    (inst_rs2),
    .immediate   (immediate)
  );

  regfile regs (
    .clock        (clock),
    .write_enable (regfile_write_enable),
    .rd_address   (inst_rd),
    .rd_data      (writeback_data),
    .rs1_address  (inst_rs1),
    .rs1_data     (rs1_data),
    .rs2_address  (inst_rs2),
    .rs2_data     (rs2_data)
  );

  assign operand_a = (alu_operand_a_select == OPA_PC) ? pc : rs1_data;
  assign operand_b = (alu_operand_b_select == OPB_IMM) ? immediate : rs2_data;

  alu alu_core (
    .alu_function      (alu_function),
    .operand_a         (operand_a),
    .operand_b         (operand_b),
    .result            (alu_result),
    .result_equal_zero (alu_result_equal_zero)
  );

  // Writeback source
  always_comb begin
    case (reg_writeback_select)
      WB_ALU:       writeback_data = alu_result;
      WB_MEM:       writeback_data = data_mem_read_data;
      WB_PC_PLUS_4: writeback_data = pc_plus_4;
      WB_IMM:       writeback_data = immediate;
      default:      writeback_data = '0;
    endcase
  end

  assign data_mem_address    = alu_result;
  assign data_mem_write_data = rs2_data;

  // Jump and branch targets must keep the PC on a word boundary
  pc_word_aligned: assert property (@(posedge clock) disable iff (reset) pc[1:0] == 2'b00)
    else $error("datapath: misaligned PC %h", pc);

endmodule

// ==== singlecycle_cpu.sv ====
// RV32I single-cycle CPU top level
// Control unit and data path wired to the instruction and data memory ports
`timescale 1ns/1ps

module singlecycle_cpu import rv_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  output logic [XLEN-1:0] inst_address,
  input  logic [31:0]     inst,
  output logic [XLEN-1:0] data_mem_address,
  output logic [XLEN-1:0] data_mem_write_data,
  output logic            data_mem_write,
  input  logic [XLEN-1:0] data_mem_read_data
);

  logic                  pc_write_enable;
  logic                  regfile_write_enable;
  logic                  alu_result_equal_zero;
  logic [6:0]            inst_opcode;
  logic [2:0]            inst_funct3;
  logic [6:0]            inst_funct7;
  alu_function_t         alu_function;
  alu_operand_a_select_t alu_operand_a_select;
  alu_operand_b_select_t alu_operand_b_select;
  next_pc_select_t       next_pc_select;
  reg_writeback_select_t reg_writeback_select;

  singlecycle_control control (
    .clock                 (clock),
    .reset                 (reset),
    .inst_opcode           (inst_opcode),
    .inst_funct3           (inst_funct3),
    .inst_funct7           (inst_funct7),
    .alu_result_equal_zero (alu_result_equal_zero),
    .pc_write_enable       (pc_write_enable),
    .regfile_write_enable  (regfile_write_enable),
    .data_mem_write        (data_mem_write),
    .alu_function          (alu_function),
    .alu_operand_a_select  (alu_operand_a_select),
    .alu_operand_b_select  (alu_operand_b_select),
    .next_pc_select        (next_pc_select),
    .reg_writeback_select  (reg_writeback_select)
  );

  // PC doubles as the instruction fetch address
  singlecycle_datapath datapath (
    .clock                 (clock),
    .reset                 (reset),
    .pc_write_enable       (pc_write_enable),
    .regfile_write_enable  (regfile_write_enable),
    .alu_function          (alu_function),
    .alu_operand_a_select  (alu_operand_a_select),
    .alu_operand_b_select  (alu_operand_b_select),
    .next_pc_select        (next_pc_select),
    .reg_writeback_select  (reg_writeback_select),
    .inst                  (inst),
    .data_mem_read_data    (data_mem_read_data),
    .data_mem_address      (data_mem_address),
    .data_mem_write_data   (data_mem_write_data),
    .alu_result_equal_zero (alu_result_equal_zero),
    .inst_funct3           (inst_funct3),
    .inst_funct7           (inst_funct7),
    .inst_opcode           (inst_opcode),
    .pc                    (inst_address)
  );

endmodule

// ==== tb_singlecycle_cpu.sv ====
// Testbench for the RV32I single-cycle CPU
// Instruction ROM and data RAM models, program builder, reference model
// and a per-cycle compare of fetch address and store traffic
`timescale 1ns/1ps

module tb_singlecycle_cpu import rv_pkg::*; ();

  localparam int          CLOCK_PERIOD   = 40;
  localparam int          SETTLE_TIME    = 1;
  localparam int          IMEM_WORDS     = 256;
  localparam int          DMEM_WORDS     = 512;
  localparam int          RUN_TIMEOUT    = 1000;
  localparam logic [31:0] MARKER_ADDRESS = 32'h0000_07fc;

  logic            clock;
  logic            reset;
  logic [XLEN-1:0] inst_address;
  logic [31:0]     inst;
  logic [XLEN-1:0] data_mem_address;
  logic [XLEN-1:0] data_mem_write_data;
  logic            data_mem_write;
  logic [XLEN-1:0] data_mem_read_data;

  logic [31:0]     imem [IMEM_WORDS];
  logic [XLEN-1:0] dmem [DMEM_WORDS];
  logic [31:0]     prog [$];
  logic [XLEN-1:0] ref_regs [32];
  logic [XLEN-1:0] ref_mem [DMEM_WORDS];
  logic [XLEN-1:0] ref_pc;
  logic [11:0]     slot;
  integer          seed = 32'hca602460;
  string           test_name;
  int              mismatch_count = 0;
  int              timeout_count = 0;

  singlecycle_cpu UUT (
    .clock               (clock),
    .reset               (reset),
    .inst_address        (inst_address),
    .inst                (inst),
    .data_mem_address    (data_mem_address),
    .data_mem_write_data (data_mem_write_data),
    .data_mem_write      (data_mem_write),
    .data_mem_read_data  (data_mem_read_data)
  );

  always #(CLOCK_PERIOD/2) clock = ~clock;

  // Memories, combinational read, RAM written at the end of the store cycle
  assign inst               = imem[inst_address[9:2]];
  assign data_mem_read_data = dmem[data_mem_address[10:2]];

  always @(posedge clock) begin
    if (data_mem_write) begin
      dmem[data_mem_address[10:2]] <= data_mem_write_data;
    end
  end

  // --------------------------------------------------------------------------
  // Instruction encoding
  // --------------------------------------------------------------------------
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPCODE_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL};
  endfunction

  // Scrambled start value, every address bit matters
  function automatic logic [XLEN-1:0] mem_fill(input int index);
    return (32'(index) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
  endfunction

  task automatic append(input logic [31:0] word);
    prog.push_back(word);
  endtask

  // LUI plus ADDI, upper part rounded for the sign of the low 12 bits
  task automatic load_constant(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    append(u_type(upper[31:12], rd, OPCODE_LUI));
    append(i_type(value[11:0], rd, 3'b000, rd, OPCODE_OP_IMM));
  endtask

  task automatic store_to_slot(input logic [4:0] rs);
    append(s_type(slot, rs, 5'd0));
    slot = slot + 12'd4;
  endtask

  // --------------------------------------------------------------------------
  // Reference model, one instruction per call
  // --------------------------------------------------------------------------
  function automatic logic [XLEN-1:0] ref_step(output logic store,
                                               output logic [XLEN-1:0] store_address,
                                               output logic [XLEN-1:0] store_data);
    logic [31:0]     word;
    logic [6:0]      op;
    logic [2:0]      f3;
    logic [4:0]      rd;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] val;
    logic [XLEN-1:0] next;
    logic            wr;
    logic            taken;
    word  = imem[ref_pc[9:2]];
    op    = word[6:0];
    f3    = word[14:12];
    rd    = word[11:7];
    a     = ref_regs[word[19:15]];
    b     = ref_regs[word[24:20]];
    imm_i = {{20{word[31]}}, word[31:20]};
    imm_s = {{20{word[31]}}, word[31:25], word[11:7]};
    imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
    imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    next  = ref_pc + 32'd4;
    wr    = 1'b0;
    val   = '0;
    taken = 1'b0;
    store = 1'b0;
    store_address = '0;
    store_data    = '0;
    case (op)
      OPCODE_LUI: begin
        wr  = 1'b1;
        val = {word[31:12], 12'b0};
      end
      OPCODE_AUIPC: begin
        wr  = 1'b1;
        val = ref_pc + {word[31:12], 12'b0};
      end
      OPCODE_JAL: begin
        wr   = 1'b1;
        val  = ref_pc + 32'd4;
        next = ref_pc + imm_j;
      end
      OPCODE_JALR: begin
        wr   = 1'b1;
        val  = ref_pc + 32'd4;
        next = (a + imm_i) & ~32'd1;
      end
      OPCODE_BRANCH: begin
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          3'b111:  taken = (a >= b);
          default: taken = 1'b0;
        endcase
        if (taken) begin
          next = ref_pc + imm_b;
        end
      end
      OPCODE_LOAD: begin
        addr = a + imm_i;
        if (f3 == 3'b010) begin
          wr  = 1'b1;
          val = ref_mem[addr[10:2]];
        end
      end
      OPCODE_STORE: begin
        if (f3 == 3'b010) begin
          store         = 1'b1;
          store_address = a + imm_s;
          store_data    = b;
          ref_mem[store_address[10:2]] = b;
        end
      end
      OPCODE_OP_IMM, OPCODE_OP: begin
        wr = 1'b1;
        if (op == OPCODE_OP_IMM) begin
          b = imm_i;
        end
        case (f3)
          3'b000: val = (op == OPCODE_OP && word[30]) ? a - b : a + b;
          3'b001: val = a << b[4:0];
          3'b010: val = {31'b0, $signed(a) < $signed(b)};
          3'b011: val = {31'b0, a < b};
          3'b100: val = a ^ b;
          3'b101: begin
            // Arithmetic shift fills with the sign bit
            if (word[30]) begin
              val = $signed(a) >>> b[4:0];
            end else begin
              val = a >> b[4:0];
            end
          end
          3'b110: val = a | b;
          default: val = a & b;
        endcase
      end
      default: ;
    endcase
    if (wr && rd != 5'd0) begin
      ref_regs[rd] = val;
    end
    return next;
  endfunction

  // --------------------------------------------------------------------------
  // Compare and run
  // --------------------------------------------------------------------------
  task automatic check_word(input string what, input logic [XLEN-1:0] expected,
                            input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH %s %s: expected %b, actual %b", test_name, what, expected, actual);
    end
  endtask

  task automatic run_program(input string name);
    logic            store;
    logic [XLEN-1:0] store_address;
    logic [XLEN-1:0] store_data;
    logic [XLEN-1:0] next_pc;
    logic            done;
    int              cycles;
    test_name = name;
    append(s_type(MARKER_ADDRESS[11:0], 5'd0, 5'd0));
    @(negedge clock);
    reset = 1'b1;
    // Unused ROM words hold a jump to self
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : j_type(21'd0, 5'd0);
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i]    = mem_fill(i);
      ref_mem[i] = mem_fill(i);
    end
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    ref_pc = INITIAL_PC;
    repeat (8) begin
      @(negedge clock);
      check_word("reset pc", INITIAL_PC, inst_address);
      check_flag("reset store", 1'b0, data_mem_write);
    end
    reset  = 1'b0;
    done   = 1'b0;
    cycles = 0;
    while (!done && cycles < RUN_TIMEOUT) begin
      #SETTLE_TIME;
      check_word("pc", ref_pc, inst_address);
      next_pc = ref_step(store, store_address, store_data);
      check_flag("store", store, data_mem_write);
      if (store) begin
        check_word("store address", store_address, data_mem_address);
        check_word("store data", store_data, data_mem_write_data);
      end
      done = data_mem_write && (data_mem_address == MARKER_ADDRESS);
      @(posedge clock);
      ref_pc = next_pc;
      @(negedge clock);
      cycles++;
    end
    if (!done) begin
      timeout_count++;
      $display("Timeout: %s never stored to the end marker within %0d cycles",
               test_name, RUN_TIMEOUT);
    end
    prog.delete();
    slot = 12'h040;
  endtask

  // --------------------------------------------------------------------------
  // Programs
  // --------------------------------------------------------------------------
  task automatic straight_line_program();
    logic [31:0] r;
    r = $random(seed);
    append(i_type(r[11:0], 5'd0, 3'b000, 5'd1, OPCODE_OP_IMM));
    append(i_type(r[23:12], 5'd1, 3'b000, 5'd2, OPCODE_OP_IMM));
    append(i_type(r[31:20], 5'd2, 3'b100, 5'd3, OPCODE_OP_IMM));
    store_to_slot(5'd3);
    run_program("straight_line");
  endtask

  task automatic alu_program();
    logic [31:0] x;
    logic [31:0] r;
    for (int pass = 0; pass < 2; pass++) begin
      x = $random(seed);
      r = $random(seed);
      // First pass has a negative rs1, second pass equal operands
      load_constant(5'd1, (pass == 0) ? (x | 32'h8000_0000) : x);
      load_constant(5'd2, (pass == 0) ? r : x);
      for (int k = 0; k < 8; k++) begin
        append(r_type(7'h00, 5'd2, 5'd1, k[2:0], 5'd5, OPCODE_OP));
        store_to_slot(5'd5);
      end
      append(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd5, OPCODE_OP));
      store_to_slot(5'd5);
      append(r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd5, OPCODE_OP));
      store_to_slot(5'd5);
      for (int k = 0; k < 8; k++) begin
        r = $random(seed);
        if (k == 1 || k == 5) begin
          r[11:5] = 7'h00;
        end
        append(i_type(r[11:0], 5'd1, k[2:0], 5'd6, OPCODE_OP_IMM));
        store_to_slot(5'd6);
      end
      r = $random(seed);
      append(i_type({7'h20, r[4:0]}, 5'd1, 3'b101, 5'd6, OPCODE_OP_IMM));
      store_to_slot(5'd6);
    end
    run_program("alu_ops");
  endtask

  task automatic branch_program();
    logic [2:0]  kinds [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    logic [31:0] a;
    logic [31:0] d;
    for (int k = 0; k < 6; k++) begin
      for (int rel = 0; rel < 3; rel++) begin
        a = $random(seed);
        d = ($random(seed) & 32'hff) + 32'd1;
        load_constant(5'd1, a);
        load_constant(5'd2, (rel == 0) ? a : ((rel == 1) ? a + d : a - d));
        // Taken branch skips the ADDI
        append(b_type(13'd8, 5'd2, 5'd1, kinds[k]));
        append(i_type(12'd1, 5'd0, 3'b000, 5'd7, OPCODE_OP_IMM));
      end
    end
    run_program("branches");
  endtask

  task automatic jump_program();
    int base;
    append(j_type(21'd12, 5'd1));
    append(i_type(12'd1, 5'd0, 3'b000, 5'd7, OPCODE_OP_IMM));
    append(i_type(12'd2, 5'd0, 3'b000, 5'd7, OPCODE_OP_IMM));
    store_to_slot(5'd1);
    // JALR target lands on an odd sum, bit 0 is dropped
    base = prog.size() * 4;
    load_constant(5'd3, 32'(base + 14));
    append(i_type(12'd3, 5'd3, 3'b000, 5'd4, OPCODE_JALR));
    append(i_type(12'd3, 5'd0, 3'b000, 5'd7, OPCODE_OP_IMM));
    store_to_slot(5'd4);
    run_program("jumps");
  endtask

  task automatic memory_program();
    logic [31:0] addr;
    logic [31:0] r;
    for (int k = 0; k < 3; k++) begin
      addr = 32'h200 + (($random(seed) & 32'hff) << 2);
      load_constant(5'd1, $random(seed));
      append(s_type(addr[11:0], 5'd1, 5'd0));
      append(i_type(addr[11:0], 5'd0, 3'b010, 5'd8, OPCODE_LOAD));
      store_to_slot(5'd8);
      addr = 32'h200 + (($random(seed) & 32'hff) << 2);
      append(i_type(addr[11:0], 5'd0, 3'b010, 5'd10, OPCODE_LOAD));
      store_to_slot(5'd10);
      r = $random(seed);
      append(u_type(r[19:0], 5'd9, OPCODE_AUIPC));
      store_to_slot(5'd9);
    end
    // Writes aimed at x0 in three forms
    append(i_type(r[31:20], 5'd0, 3'b000, 5'd0, OPCODE_OP_IMM));
    append(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd0, OPCODE_OP));
    append(i_type(addr[11:0], 5'd0, 3'b010, 5'd0, OPCODE_LOAD));
    store_to_slot(5'd0);
    run_program("load_store");
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    slot  = 12'h040;
    straight_line_program();
    alu_program();
    branch_program();
    jump_program();
    memory_program();
    $display("Summary: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== simple_rv.f ====
rv_pkg.sv
alu.sv
regfile.sv
instruction_decoder.sv
singlecycle_control.sv
singlecycle_datapath.sv
singlecycle_cpu.sv
tb_singlecycle_cpu.sv

// ==== Bender.yml ====
package:
  name: simple_rv

sources:
  - rv_pkg.sv
  - alu.sv
  - regfile.sv
  - instruction_decoder.sv
  - singlecycle_control.sv
  - singlecycle_datapath.sv
  - singlecycle_cpu.sv
  - target: test
    files:
      - tb_singlecycle_cpu.sv
